/* wb_intercon_cfg.svh */
`ifndef WB_INTERCON_CFG_SVH
`define WB_INTERCON_CFG_SVH

// Bus widths
`define WB_ADR_W         22
`define WB_DAT_W         32
// Byte address width inside one 4 KB target window
`define WB_LOC_ADR_W     12

`define WB_N_MASTERS     4
`define WB_N_TARGETS     4

// Decode compares bits 13:12 only and ignores bits 21:14
`define WB_TGT_MASK      22'h003000
`define WB_BASE_ID       22'h000000
`define WB_BASE_SHIFT    22'h001000
`define WB_BASE_LINK     22'h002000
`define WB_BASE_HSK      22'h003000

// Words per register file, word 0 being the identity word
`define WB_REG_WORDS     8
// Identity of target 0; the other targets count up from it
`define WB_ID_VALUE_BASE 32'h1D000000

`endif

/* wb_bus_pkg.sv */
`default_nettype none

`include "wb_intercon_cfg.svh"

package wb_bus_pkg;

    typedef logic [`WB_ADR_W-1:0]     adr_t;
    typedef logic [`WB_LOC_ADR_W-1:0] loc_adr_t;
    typedef logic [`WB_DAT_W-1:0]     dat_t;
    typedef logic [`WB_DAT_W/8-1:0]   sel_t;

    // Completion of one transfer as seen on the bus
    typedef enum logic [1:0] {
        resp_none = 2'd0,
        resp_ack  = 2'd1,
        resp_err  = 2'd2
    } resp_e;

endpackage

`default_nettype wire

/* wb_map_pkg.sv */
`default_nettype none

package wb_map_pkg;

    // Bus masters in arbiter index order
    typedef enum logic [1:0] {
        mst_gtp = 2'd0,
        mst_ctl = 2'd1,
        mst_dbg = 2'd2,
        mst_ser = 2'd3
    } master_e;

    // Targets in decode window order
    typedef enum logic [1:0] {
        tgt_id_ctrl = 2'd0,
        tgt_shift   = 2'd1,
        tgt_link    = 2'd2,
        tgt_hsk     = 2'd3
    } target_e;

    typedef enum logic {arb_idle, arb_owned} arb_state_e;

    typedef enum logic {tgt_st_wait, tgt_st_respond} tgt_state_e;

endpackage

`default_nettype wire

/* wb_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_intercon_cfg.svh"

module wb_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`WB_N_MASTERS-1:0] req_i,
    output logic [`WB_N_MASTERS-1:0] gnt_o
);

    localparam int PTR_W = $clog2(`WB_N_MASTERS);

    wb_map_pkg::arb_state_e   state_q;
    logic [PTR_W-1:0]         ptr_q;
    logic [PTR_W-1:0]         winner;
    logic [`WB_N_MASTERS-1:0] win_vec;
    logic                     found;

    // Search starts at the master after the last owner and wraps
    always_comb begin : pick
        logic [PTR_W-1:0] idx;
        winner  = ptr_q;
        found   = 1'b0;
        win_vec = '0;
        for (int k = 0; k < `WB_N_MASTERS; k++) begin
            idx = ptr_q + PTR_W'(k);
            if (!found && req_i[idx]) begin
                winner = idx;
                found  = 1'b1;
            end
        end
        win_vec[winner] = found;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= wb_map_pkg::arb_idle;
            ptr_q   <= '0;
            gnt_o   <= '0;
        end else begin
            case (state_q)
                wb_map_pkg::arb_idle: begin
                    if (found) begin
                        state_q <= wb_map_pkg::arb_owned;
                        gnt_o   <= win_vec;
                        ptr_q   <= winner + PTR_W'(1);
                    end
                end
                wb_map_pkg::arb_owned: begin
                    // Owner ends its bus cycle by dropping cyc
                    if (!(|(req_i & gnt_o))) begin
                        state_q <= wb_map_pkg::arb_idle;
                        gnt_o   <= '0;
                    end
                end
                default: state_q <= wb_map_pkg::arb_idle;
            endcase
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(gnt_o));

    a_gnt_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|(req_i & gnt_o)) |=> $stable(gnt_o));

endmodule

`default_nettype wire

/* wb_master_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_intercon_cfg.svh"

module wb_master_mux (
    input  logic [`WB_N_MASTERS-1:0]                   gnt_i,
    input  logic [`WB_N_MASTERS-1:0]                   cyc_i,
    input  logic [`WB_N_MASTERS-1:0]                   stb_i,
    input  logic [`WB_N_MASTERS-1:0]                   we_i,
    input  wb_bus_pkg::adr_t [`WB_N_MASTERS-1:0]       adr_i,
    input  wb_bus_pkg::dat_t [`WB_N_MASTERS-1:0]       dat_i,
    input  wb_bus_pkg::sel_t [`WB_N_MASTERS-1:0]       sel_i,
    output logic [`WB_N_MASTERS-1:0]                   ack_o,
    output logic [`WB_N_MASTERS-1:0]                   err_o,
    output wb_bus_pkg::dat_t [`WB_N_MASTERS-1:0]       dat_o,
    output logic                                       bus_cyc_o,
    output logic                                       bus_stb_o,
    output logic                                       bus_we_o,
    output wb_bus_pkg::adr_t                           bus_adr_o,
    output wb_bus_pkg::dat_t                           bus_dat_o,
    output wb_bus_pkg::sel_t                           bus_sel_o,
    input  wb_bus_pkg::resp_e                          bus_resp_i,
    input  wb_bus_pkg::dat_t                           bus_dat_i
);

    wb_map_pkg::master_e mst_idx;

    function automatic wb_map_pkg::master_e gnt_to_idx(input logic [`WB_N_MASTERS-1:0] gnt);
        wb_map_pkg::master_e idx;
        idx = wb_map_pkg::mst_gtp;
        for (int m = 0; m < `WB_N_MASTERS; m++) begin
            if (gnt[m]) begin
                idx = wb_map_pkg::master_e'(m);
            end
        end
        return idx;
    endfunction

    assign mst_idx = gnt_to_idx(gnt_i);

    // Strobes are gated by the grant so an idle arbiter leaves the bus quiet
    assign bus_cyc_o = |(cyc_i & gnt_i);
    assign bus_stb_o = |(stb_i & gnt_i);
    assign bus_we_o  = we_i[mst_idx];
    assign bus_adr_o = adr_i[mst_idx];
    assign bus_dat_o = dat_i[mst_idx];
    assign bus_sel_o = sel_i[mst_idx];

    // Only the owner sees the response
    assign ack_o = {`WB_N_MASTERS{bus_resp_i == wb_bus_pkg::resp_ack}} & gnt_i;
    assign err_o = {`WB_N_MASTERS{bus_resp_i == wb_bus_pkg::resp_err}} & gnt_i;

    always_comb begin
        for (int m = 0; m < `WB_N_MASTERS; m++) begin
            dat_o[m] = gnt_i[m] ? bus_dat_i : '0;
        end
    end

endmodule

`default_nettype wire

/* wb_addr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_intercon_cfg.svh"

module wb_addr_decoder (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    input  logic                                       bus_cyc_i,
    input  logic                                       bus_stb_i,
    input  wb_bus_pkg::adr_t                           bus_adr_i,
    output wb_bus_pkg::resp_e                          bus_resp_o,
    output wb_bus_pkg::dat_t                           bus_dat_o,
    output logic [`WB_N_TARGETS-1:0]                   tgt_cyc_o,
    output logic [`WB_N_TARGETS-1:0]                   tgt_stb_o,
    output wb_bus_pkg::loc_adr_t                       tgt_adr_o,
    input  wb_bus_pkg::resp_e [`WB_N_TARGETS-1:0]      tgt_resp_i,
    input  wb_bus_pkg::dat_t [`WB_N_TARGETS-1:0]       tgt_dat_i
);

    // Window bases in target index order
    localparam wb_bus_pkg::adr_t BASE [`WB_N_TARGETS] = '{
        `WB_BASE_ID,
        `WB_BASE_SHIFT,
        `WB_BASE_LINK,
        `WB_BASE_HSK
    };
    localparam wb_bus_pkg::adr_t MASK = `WB_TGT_MASK;

    logic [`WB_N_TARGETS-1:0] hit;
    wb_map_pkg::target_e      tgt_idx;

    always_comb begin
        for (int t = 0; t < `WB_N_TARGETS; t++) begin
            hit[t] = ((bus_adr_i & MASK) == BASE[t]);
        end
    end

    always_comb begin
        tgt_idx = wb_map_pkg::tgt_id_ctrl;
        for (int t = 0; t < `WB_N_TARGETS; t++) begin
            if (hit[t]) begin
                tgt_idx = wb_map_pkg::target_e'(t);
            end
        end
    end

    assign tgt_cyc_o = {`WB_N_TARGETS{bus_cyc_i}} & hit;
    assign tgt_stb_o = {`WB_N_TARGETS{bus_stb_i}} & hit;
    // Upper bits are dropped so every shadow alias lands on the same word
    assign tgt_adr_o = bus_adr_i[`WB_LOC_ADR_W-1:0];

    assign bus_resp_o = tgt_resp_i[tgt_idx];
    assign bus_dat_o  = tgt_dat_i[tgt_idx];

    a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus_cyc_i |-> $onehot(hit));

endmodule

`default_nettype wire

/* wb_reg_target.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_intercon_cfg.svh"

module wb_reg_target #(
    parameter wb_bus_pkg::dat_t ID_VALUE  = '0,
    parameter int               REG_WORDS = `WB_REG_WORDS
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 cyc_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  wb_bus_pkg::loc_adr_t adr_i,
    input  wb_bus_pkg::dat_t     dat_i,
    input  wb_bus_pkg::sel_t     sel_i,
    output wb_bus_pkg::resp_e    resp_o,
    output wb_bus_pkg::dat_t     dat_o
);

    localparam int IDX_W = `WB_LOC_ADR_W - 2;

    wb_map_pkg::tgt_state_e state_q;
    wb_bus_pkg::resp_e      resp_q;
    wb_bus_pkg::dat_t       dat_q;
    wb_bus_pkg::dat_t       regs_q [1:REG_WORDS-1];
    wb_bus_pkg::dat_t       rd_word;
    logic [IDX_W-1:0]       word_idx;
    logic                   strobe;
    logic                   in_range;
    logic                   bad;

    // Byte address to word index
    assign word_idx = adr_i[`WB_LOC_ADR_W-1:2];
    assign strobe   = cyc_i && stb_i;
    assign in_range = (word_idx < IDX_W'(REG_WORDS));
    // Identity word is read only
    assign bad      = !in_range || (we_i && (word_idx == '0));

    always_comb begin
        rd_word = ID_VALUE;
        for (int w = 1; w < REG_WORDS; w++) begin
            if (word_idx == IDX_W'(w)) begin
                rd_word = regs_q[w];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= wb_map_pkg::tgt_st_wait;
            resp_q  <= wb_bus_pkg::resp_none;
            dat_q   <= '0;
            for (int w = 1; w < REG_WORDS; w++) begin
                regs_q[w] <= '0;
            end
        end else if (state_q == wb_map_pkg::tgt_st_wait) begin
            if (strobe) begin
                state_q <= wb_map_pkg::tgt_st_respond;
                resp_q  <= bad ? wb_bus_pkg::resp_err : wb_bus_pkg::resp_ack;
                dat_q   <= (!we_i && in_range) ? rd_word : '0;
                for (int w = 1; w < REG_WORDS; w++) begin
                    for (int b = 0; b < `WB_DAT_W / 8; b++) begin
                        if (we_i && (word_idx == IDX_W'(w)) && sel_i[b]) begin
                            regs_q[w][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end
                end
            end
        end else begin
            // Master drops its strobe while the response is out
            state_q <= wb_map_pkg::tgt_st_wait;
            resp_q  <= wb_bus_pkg::resp_none;
            dat_q   <= '0;
        end
    end

    assign resp_o = resp_q;
    assign dat_o  = dat_q;

    a_resp_after_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (resp_o != wb_bus_pkg::resp_none) |-> $past(strobe));

endmodule

`default_nettype wire

/* wb_intercon_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_intercon_cfg.svh"

module wb_intercon_top (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic [`WB_N_MASTERS-1:0]             m_cyc_i,
    input  logic [`WB_N_MASTERS-1:0]             m_stb_i,
    input  logic [`WB_N_MASTERS-1:0]             m_we_i,
    input  wb_bus_pkg::adr_t [`WB_N_MASTERS-1:0] m_adr_i,
    input  wb_bus_pkg::dat_t [`WB_N_MASTERS-1:0] m_dat_i,
    input  wb_bus_pkg::sel_t [`WB_N_MASTERS-1:0] m_sel_i,
    output logic [`WB_N_MASTERS-1:0]             m_ack_o,
    output logic [`WB_N_MASTERS-1:0]             m_err_o,
    output wb_bus_pkg::dat_t [`WB_N_MASTERS-1:0] m_dat_o
);

    logic [`WB_N_MASTERS-1:0]                 gnt;
    logic                                     bus_cyc;
    logic                                     bus_stb;
    logic                                     bus_we;
    wb_bus_pkg::adr_t                         bus_adr;
    wb_bus_pkg::dat_t                         bus_wdat;
    wb_bus_pkg::sel_t                         bus_sel;
    wb_bus_pkg::resp_e                        bus_resp;
    wb_bus_pkg::dat_t                         bus_rdat;
    logic [`WB_N_TARGETS-1:0]                 tgt_cyc;
    logic [`WB_N_TARGETS-1:0]                 tgt_stb;
    wb_bus_pkg::loc_adr_t                     tgt_adr;
    wb_bus_pkg::resp_e [`WB_N_TARGETS-1:0]    tgt_resp;
    wb_bus_pkg::dat_t [`WB_N_TARGETS-1:0]     tgt_rdat;

    // A master requests the bus by raising cyc
    wb_arbiter u_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (m_cyc_i),
        .gnt_o   (gnt)
    );

    wb_master_mux u_mux (
        .gnt_i      (gnt),
        .cyc_i      (m_cyc_i),
        .stb_i      (m_stb_i),
        .we_i       (m_we_i),
        .adr_i      (m_adr_i),
        .dat_i      (m_dat_i),
        .sel_i      (m_sel_i),
        .ack_o      (m_ack_o),
        .err_o      (m_err_o),
        .dat_o      (m_dat_o),
        .bus_cyc_o  (bus_cyc),
        .bus_stb_o  (bus_stb),
        .bus_we_o   (bus_we),
        .bus_adr_o  (bus_adr),
        .bus_dat_o  (bus_wdat),
        .bus_sel_o  (bus_sel),
        .bus_resp_i (bus_resp),
        .bus_dat_i  (bus_rdat)
    );

    wb_addr_decoder u_decoder (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .bus_cyc_i  (bus_cyc),
        .bus_stb_i  (bus_stb),
        .bus_adr_i  (bus_adr),
        .bus_resp_o (bus_resp),
        .bus_dat_o  (bus_rdat),
        .tgt_cyc_o  (tgt_cyc),
        .tgt_stb_o  (tgt_stb),
        .tgt_adr_o  (tgt_adr),
        .tgt_resp_i (tgt_resp),
        .tgt_dat_i  (tgt_rdat)
    );

    // Write data, we and byte selects go to all targets
    for (genvar t = 0; t < `WB_N_TARGETS; t++) begin : g_tgt
        wb_reg_target #(
            .ID_VALUE  (`WB_ID_VALUE_BASE + t),
            .REG_WORDS (`WB_REG_WORDS)
        ) u_target (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .cyc_i   (tgt_cyc[t]),
            .stb_i   (tgt_stb[t]),
            .we_i    (bus_we),
            .adr_i   (tgt_adr),
            .dat_i   (bus_wdat),
            .sel_i   (bus_sel),
            .resp_o  (tgt_resp[t]),
            .dat_o   (tgt_rdat[t])
        );
    end

endmodule

`default_nettype wire

/* tb_wb_intercon.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wb_intercon_cfg.svh"

module tb_wb_intercon;

    localparam int               WAIT_LIMIT = 50;
    // Identity of target 0, the others follow in target order
    localparam wb_bus_pkg::dat_t ID_BASE    = 32'h1D000000;

    logic                                     clk = 1'b0;
    logic                                     rst_n;
    logic [`WB_N_MASTERS-1:0]                 m_cyc;
    logic [`WB_N_MASTERS-1:0]                 m_stb;
    logic [`WB_N_MASTERS-1:0]                 m_we;
    wb_bus_pkg::adr_t [`WB_N_MASTERS-1:0]     m_adr;
    wb_bus_pkg::dat_t [`WB_N_MASTERS-1:0]     m_wdat;
    wb_bus_pkg::sel_t [`WB_N_MASTERS-1:0]     m_sel;
    wire logic [`WB_N_MASTERS-1:0]            m_ack;
    wire logic [`WB_N_MASTERS-1:0]            m_err;
    wire wb_bus_pkg::dat_t [`WB_N_MASTERS-1:0] m_rdat;

    // Expected contents of every register file with the identity in word 0
    wb_bus_pkg::dat_t model [`WB_N_TARGETS][`WB_REG_WORDS];
    logic [31:0]      rng_state;
    int               resp_cnt [`WB_N_MASTERS];
    int               n_dat_err;
    int               n_resp_err;
    int               n_other_err;

    wb_intercon_top dut (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .m_cyc_i (m_cyc),
        .m_stb_i (m_stb),
        .m_we_i  (m_we),
        .m_adr_i (m_adr),
        .m_dat_i (m_wdat),
        .m_sel_i (m_sel),
        .m_ack_o (m_ack),
        .m_err_o (m_err),
        .m_dat_o (m_rdat)
    );

    always #4 clk = ~clk;

    // Counts response pulses per master; only the owner may see one
    always @(negedge clk) begin
        if (rst_n) begin
            for (int m = 0; m < `WB_N_MASTERS; m++) begin
                if (m_ack[m] || m_err[m]) begin
                    resp_cnt[m] = resp_cnt[m] + 1;
                end
            end
            if (!$onehot0(m_ack | m_err)) begin
                $display("Protocol failure at %0t: several masters got a response at once",
                         $time);
                n_other_err++;
            end
            // Masters without the response must read zero
            if ($onehot(m_ack | m_err)) begin
                for (int m = 0; m < `WB_N_MASTERS; m++) begin
                    if (!(m_ack[m] || m_err[m]) && m_rdat[m] !== '0) begin
                        $display("** Error at %0t: master %0d read data %h without a response",
                                 $time, m, m_rdat[m]);
                        n_dat_err++;
                    end
                end
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Target window in bits 13:12, word index in 11:2, shadow bits on top
    function automatic wb_bus_pkg::adr_t word_adr(input int t, input int w,
                                                  input logic [7:0] upper);
        return {upper, 2'(t), 10'(w), 2'b00};
    endfunction

    task automatic check_dat(input wb_bus_pkg::dat_t got, input wb_bus_pkg::dat_t exp,
                             input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s read data %h, expected %h", $time, what, got, exp);
            n_dat_err++;
        end
    endtask

    task automatic check_resp(input wb_bus_pkg::resp_e got, input wb_bus_pkg::resp_e exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s response %s, expected %s", $time, what,
                     got.name(), exp.name());
            n_resp_err++;
        end
    endtask

    task automatic verify_resp_counts();
        for (int m = 0; m < `WB_N_MASTERS; m++) begin
            if (resp_cnt[m] != 1) begin
                $display("** Error at %0t: master %0d saw %0d responses, expected one",
                         $time, m, resp_cnt[m]);
                n_other_err++;
            end
            resp_cnt[m] = 0;
        end
    endtask

    // One Wishbone classic transfer from master m
    task automatic bus_xfer(input int m, input logic we, input wb_bus_pkg::adr_t adr,
                            input wb_bus_pkg::dat_t wdat, input wb_bus_pkg::sel_t sel,
                            output wb_bus_pkg::resp_e resp, output wb_bus_pkg::dat_t rdat);
        int  waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        resp   = wb_bus_pkg::resp_none;
        rdat   = '0;
        @(posedge clk);
        m_cyc[m]  <= 1'b1;
        m_stb[m]  <= 1'b1;
        m_we[m]   <= we;
        m_adr[m]  <= adr;
        m_wdat[m] <= wdat;
        m_sel[m]  <= sel;
        while (!done && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (m_ack[m] || m_err[m]) begin
                done = 1'b1;
                resp = m_err[m] ? wb_bus_pkg::resp_err : wb_bus_pkg::resp_ack;
                rdat = m_rdat[m];
            end
            waited++;
        end
        if (!done) begin
            $display("Timeout at %0t: master %0d got no ack or err for address %h",
                     $time, m, adr);
            n_other_err++;
        end
        @(posedge clk);
        m_cyc[m] <= 1'b0;
        m_stb[m] <= 1'b0;
    endtask

    // Transfer checked against the register model
    task automatic access(input int m, input logic we, input wb_bus_pkg::adr_t adr,
                          input wb_bus_pkg::dat_t wdat, input wb_bus_pkg::sel_t sel);
        int                t;
        int                w;
        string             what;
        wb_bus_pkg::resp_e exp_resp;
        wb_bus_pkg::dat_t  exp_dat;
        wb_bus_pkg::resp_e got_resp;
        wb_bus_pkg::dat_t  got_dat;
        t        = adr[13:12];
        w        = adr[11:2];
        exp_resp = (w >= `WB_REG_WORDS || (we && w == 0)) ? wb_bus_pkg::resp_err
                                                           : wb_bus_pkg::resp_ack;
        exp_dat  = (!we && exp_resp == wb_bus_pkg::resp_ack) ? model[t][w] : '0;
        what     = $sformatf("master %0d %s at %h", m, we ? "write" : "read", adr);
        bus_xfer(m, we, adr, wdat, sel, got_resp, got_dat);
        check_resp(got_resp, exp_resp, what);
        if (!we) begin
            check_dat(got_dat, exp_dat, what);
        end else if (exp_resp == wb_bus_pkg::resp_ack) begin
            for (int b = 0; b < `WB_DAT_W / 8; b++) begin
                if (sel[b]) begin
                    model[t][w][8*b +: 8] = wdat[8*b +: 8];
                end
            end
        end
    endtask

    task automatic reset_state_reads();
        @(negedge clk);
        for (int m = 0; m < `WB_N_MASTERS; m++) begin
            check_resp(m_err[m] ? wb_bus_pkg::resp_err :
                       m_ack[m] ? wb_bus_pkg::resp_ack : wb_bus_pkg::resp_none,
                       wb_bus_pkg::resp_none, $sformatf("master %0d after reset", m));
        end
        for (int t = 0; t < `WB_N_TARGETS; t++) begin
            for (int w = 0; w < `WB_REG_WORDS; w++) begin
                access(t, 1'b0, word_adr(t, w, 8'h00), '0, 4'hF);
            end
        end
    endtask

    task automatic byte_select_rw();
        logic [31:0] r;
        logic [31:0] s;
        int          w;
        for (int m = 0; m < `WB_N_MASTERS; m++) begin
            for (int t = 0; t < `WB_N_TARGETS; t++) begin
                for (int k = 0; k < 3; k++) begin
                    r = next_rand();
                    w = 1 + int'(r % 7);
                    s = next_rand();
                    access(m, 1'b1, word_adr(t, w, 8'h00), next_rand(), s[3:0]);
                    access((m + 1) % 4, 1'b0, word_adr(t, w, 8'h00), '0, 4'hF);
                end
            end
        end
        // Sweep catches a byte lane that landed in the wrong word
        for (int t = 0; t < `WB_N_TARGETS; t++) begin
            for (int w = 0; w < `WB_REG_WORDS; w++) begin
                access(3, 1'b0, word_adr(t, w, 8'h00), '0, 4'hF);
            end
        end
    endtask

    task automatic shadow_alias_rw();
        for (int t = 0; t < `WB_N_TARGETS; t++) begin
            access(t, 1'b1, word_adr(t, t + 1, 8'hFF), next_rand(), 4'hF);
            access((t + 2) % 4, 1'b0, word_adr(t, t + 1, 8'h00), '0, 4'hF);
            access(t, 1'b1, word_adr(t, t + 2, 8'h00), next_rand(), 4'hF);
            access((t + 1) % 4, 1'b0, word_adr(t, t + 2, 8'h5A), '0, 4'hF);
            access(t, 1'b0, word_adr(t, 0, 8'hC3), '0, 4'hF);
        end
    endtask

    task automatic error_responses();
        for (int t = 0; t < `WB_N_TARGETS; t++) begin
            access(t, 1'b1, word_adr(t, 0, 8'h00), next_rand(), 4'hF);
            access(t, 1'b0, word_adr(t, 0, 8'h00), '0, 4'hF);
            access(t, 1'b0, word_adr(t, 8, 8'h00), '0, 4'hF);
            access(t, 1'b1, word_adr(t, 9, 8'h00), next_rand(), 4'hF);
            access(t, 1'b0, word_adr(t, 1023, 8'h00), '0, 4'hF);
        end
    endtask

    task automatic four_master_contention();
        wb_bus_pkg::dat_t wd [`WB_N_MASTERS];
        for (int m = 0; m < `WB_N_MASTERS; m++) begin
            wd[m] = next_rand();
            resp_cnt[m] = 0;
        end
        fork
            access(0, 1'b1, word_adr(1, 3, 8'h00), wd[0], 4'hF);
            access(1, 1'b1, word_adr(2, 4, 8'h00), wd[1], 4'h5);
            access(2, 1'b1, word_adr(3, 5, 8'h00), wd[2], 4'hA);
            access(3, 1'b1, word_adr(0, 6, 8'h00), wd[3], 4'hF);
        join
        verify_resp_counts();
        fork
            access(0, 1'b0, word_adr(1, 3, 8'h00), '0, 4'hF);
            access(1, 1'b0, word_adr(2, 4, 8'h00), '0, 4'hF);
            access(2, 1'b0, word_adr(3, 5, 8'h00), '0, 4'hF);
            access(3, 1'b0, word_adr(0, 6, 8'h00), '0, 4'hF);
        join
        verify_resp_counts();
    endtask

    initial begin
        rst_n       = 1'b0;
        m_cyc       = '0;
        m_stb       = '0;
        m_we        = '0;
        m_adr       = '0;
        m_wdat      = '0;
        m_sel       = '0;
        rng_state   = 32'h5588;
        n_dat_err   = 0;
        n_resp_err  = 0;
        n_other_err = 0;
        for (int t = 0; t < `WB_N_TARGETS; t++) begin
            for (int w = 0; w < `WB_REG_WORDS; w++) begin
                model[t][w] = (w == 0) ? ID_BASE + 32'(t) : '0;
            end
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        reset_state_reads();
        byte_select_rw();
        shadow_alias_rw();
        error_responses();
        four_master_contention();
        repeat (4) @(posedge clk);
        $display("Summary: %0d data errors, %0d response errors, %0d other errors",
                 n_dat_err, n_resp_err, n_other_err);
        if (n_dat_err + n_resp_err + n_other_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
wb_bus_pkg.sv
wb_map_pkg.sv
wb_arbiter.sv
wb_master_mux.sv
wb_addr_decoder.sv
wb_reg_target.sv
wb_intercon_top.sv
tb_wb_intercon.sv
